/* gpu_display_pkg.sv */
// gpu display package
// raster timing, memory map, latencies and shared types
package gpu_display_pkg;

  // vector types with a meaning
  typedef logic [9:0]  coord_t;
  typedef logic [23:0] mem_addr_t;
  typedef logic [3:0]  nibble_t;
  typedef logic [9:0]  tri_count_t;
  typedef logic [15:0] byte_idx_t;
  typedef logic [17:0] beat_cnt_t;

  // 640x480 raster
  localparam coord_t H_TOTAL      = 10'd800;
  localparam coord_t V_TOTAL      = 10'd525;
  localparam coord_t H_VISIBLE    = 10'd640;
  localparam coord_t V_VISIBLE    = 10'd480;
  localparam coord_t H_SYNC_START = 10'd656;
  localparam coord_t H_SYNC_END   = 10'd752;
  localparam coord_t V_SYNC_START = 10'd490;
  localparam coord_t V_SYNC_END   = 10'd492;

  // displayed window, upper left
  localparam coord_t WIN_W = 10'd320;
  localparam coord_t WIN_H = 10'd240;

  // position ticks
  localparam coord_t QUAD_X    = 10'd775;
  localparam coord_t FETCH_X   = 10'd783;
  localparam coord_t LAST_LINE = 10'd524;

  // ram map
  localparam mem_addr_t FRONT_BASE_A = 24'd0;
  localparam mem_addr_t FRONT_BASE_B = 24'd38400;
  localparam mem_addr_t Z_BASE       = 24'd76800;
  localparam mem_addr_t TRI_BASE     = 24'd153600;
  localparam mem_addr_t LINE_NIBBLES = 24'd160;

  // scene and buffer sizes
  localparam beat_cnt_t Z_NIBBLES     = 18'd153600;
  localparam byte_idx_t TEX_BYTES     = 16'd32768;
  localparam byte_idx_t TRI_BYTES     = 16'd22;
  localparam byte_idx_t TRI_BYTES_TEX = 16'd28;

  // first read nibble latency
  localparam logic [4:0] FLASH_WAIT = 5'd24;
  localparam logic [4:0] RAM_WAIT   = 5'd16;

  localparam nibble_t Z_FAR_NIBBLE = 4'hf;
  localparam nibble_t BLACK_NIBBLE = 4'h0;

  typedef enum logic [4:0] {
    QUAD_ENTER, QUAD_WAIT, HDR_START, HDR_WAIT, HDR_READ, HDR_LATCH,
    COPY_CHECK, COPY_WAIT, COPY_READ, COPY_WR_START, COPY_WR,
    LINE_WAIT_EOF, LINE_FILL, LINE_READ, BACK_CLR_START, BACK_CLR,
    LINE_WAIT_EOL, Z_CLR_START, Z_CLR
  } state_t;

  typedef enum logic [2:0] {
    ADDR_HDR, ADDR_COPY_RD, ADDR_COPY_WR, ADDR_FRONT_LINE, ADDR_BACK_LINE, ADDR_Z
  } addr_sel_t;

endpackage

/* disp_ctrl_if.sv */
// controller command bundle
// fsm commands out to the datapath, status flags back
interface disp_ctrl_if import gpu_display_pkg::*; ();

  addr_sel_t addr_sel;
  logic      hdr_capture;
  logic      hdr_latch;
  logic      buf_capture;
  logic      wr_next;
  logic      copy_advance;
  logic      frame_start;
  logic      swap;
  // status back to the fsm
  logic      has_tex;
  logic      copy_done;
  logic      clear_pass;

  modport ctl (
    output addr_sel, hdr_capture, hdr_latch, buf_capture, wr_next,
    output copy_advance, frame_start, swap,
    input  has_tex, copy_done, clear_pass
  );

  modport dp (
    input  addr_sel, hdr_capture, hdr_latch, buf_capture, wr_next,
    input  copy_advance, frame_start, swap,
    output has_tex, copy_done, clear_pass
  );

endinterface

/* vga_scan.sv */
// vga scan generator
// pixel and line counters, syncs, fsm ticks and window blanking
module vga_scan import gpu_display_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  nibble_t i_front_nibble,
  output logic    o_hs,
  output logic    o_vs,
  output nibble_t o_pixel,
  output coord_t  o_x,
  output coord_t  o_y,
  output logic    o_quad_tick,
  output logic    o_eof_tick,
  output logic    o_eol_tick
);

  coord_t x;
  coord_t y;
  logic   in_window;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x <= '0;
      y <= '0;
    end else if (x == H_TOTAL - 1'b1) begin
      x <= '0;
      // wrap after the last blank line
      y <= (y == V_TOTAL - 1'b1) ? '0 : y + 1'b1;
    end else begin
      x <= x + 1'b1;
    end
  end

  // negative syncs
  assign o_hs = !((x >= H_SYNC_START) && (x < H_SYNC_END));
  assign o_vs = !((y >= V_SYNC_START) && (y < V_SYNC_END));

  assign o_x = x;
  assign o_y = y;

  // quad mode entry late in the last line
  assign o_quad_tick = (y == LAST_LINE) && (x == QUAD_X);
  // fetch of line 0, ram wait ahead of x 0
  assign o_eof_tick  = (y == LAST_LINE) && (x == FETCH_X);
  // fetch of the next window line
  assign o_eol_tick  = (y < WIN_H - 1'b1) && (x == FETCH_X);

  // only the 320x240 corner carries image
  assign in_window = (x < WIN_W) && (y < WIN_H);
  assign o_pixel   = in_window ? i_front_nibble : BLACK_NIBBLE;

  a_x_range: assert property (@(posedge clk) disable iff (!rst_n) x < H_TOTAL);

endmodule

/* beat_counter.sv */
// burst beat counter
// counts transferred nibbles and the wait before the first read nibble
module beat_counter import gpu_display_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      i_clear,
  input  logic      i_step,
  input  logic      i_wait,
  input  logic      i_flash,
  output beat_cnt_t o_beats,
  output logic      o_wait_done
);

  logic [4:0] wait_cnt;

  // flash needs the longer dummy phase
  assign o_wait_done = (wait_cnt == (i_flash ? FLASH_WAIT : RAM_WAIT));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_beats  <= '0;
      wait_cnt <= '0;
    end else if (i_clear) begin
      o_beats  <= '0;
      wait_cnt <= '0;
    end else begin
      if (i_step) begin
        o_beats <= o_beats + 1'b1;
      end
      // restart for the next burst
      if (i_wait) begin
        wait_cnt <= o_wait_done ? '0 : wait_cnt + 1'b1;
      end
    end
  end

endmodule

/* display_fsm.sv */
// main display and memory controller FSM
// quad mode, header, scene copy, line fetch, back and depth clear
module display_fsm import gpu_display_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  disp_ctrl_if.ctl  ctl,
  input  logic      i_at_quadmode,
  input  logic      i_data_req,
  input  logic      i_do_swap,
  input  coord_t    i_y,
  input  logic      i_quad_tick,
  input  logic      i_eof_tick,
  input  logic      i_eol_tick,
  input  beat_cnt_t i_beats,
  input  logic      i_wait_done,
  output logic      o_enter_quadmode,
  output logic      o_select_rom,
  output logic      o_start_read,
  output logic      o_start_write,
  output logic      o_stop_txn,
  output logic      o_render_start,
  output logic      o_beat_clear,
  output logic      o_beat_step,
  output logic      o_beat_wait,
  output logic      o_beat_flash
);

  state_t state;
  logic   wr_state;
  logic   line_last;

  assign wr_state  = state inside {COPY_WR, BACK_CLR, Z_CLR};
  assign line_last = (i_beats == beat_cnt_t'(WIN_W) - 1'b1);

  // beat counter control
  assign o_beat_clear = state inside {HDR_START, COPY_CHECK, COPY_WR_START, LINE_WAIT_EOF,
                                      LINE_WAIT_EOL, BACK_CLR_START, Z_CLR_START};
  assign o_beat_wait  = state inside {HDR_WAIT, COPY_WAIT, LINE_FILL};
  assign o_beat_flash = state inside {HDR_WAIT, COPY_WAIT};
  // reads stream every clock, writes only on data request
  assign o_beat_step  = (state inside {HDR_READ, COPY_READ, LINE_READ})
                      || (wr_state && i_data_req);

  // datapath commands
  assign ctl.hdr_capture  = (state == HDR_READ);
  assign ctl.hdr_latch    = (state == HDR_LATCH);
  assign ctl.buf_capture  = (state == COPY_READ);
  assign ctl.wr_next      = (state == COPY_WR) && i_data_req;
  assign ctl.copy_advance = ctl.wr_next && (i_beats == 18'd3);
  assign ctl.swap         = (state == LINE_WAIT_EOF) && i_do_swap;
  assign ctl.frame_start  = (state == LINE_WAIT_EOF) && !i_do_swap && i_eof_tick;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state            <= QUAD_ENTER;
      ctl.addr_sel     <= ADDR_HDR;
      o_enter_quadmode <= 1'b0;
      o_select_rom     <= 1'b0;
      o_start_read     <= 1'b0;
      o_start_write    <= 1'b0;
      o_stop_txn       <= 1'b0;
      o_render_start   <= 1'b0;
    end else begin
      // strobes are single cycle
      o_enter_quadmode <= 1'b0;
      o_start_read     <= 1'b0;
      o_start_write    <= 1'b0;
      o_stop_txn       <= 1'b0;
      o_render_start   <= 1'b0;
      case (state)
        QUAD_ENTER: if (i_quad_tick) begin
          o_enter_quadmode <= 1'b1;
          state            <= QUAD_WAIT;
        end
        QUAD_WAIT: if (i_at_quadmode) begin
          o_stop_txn <= 1'b1;
          state      <= HDR_START;
        end
        // header, 3 bytes from flash 0
        HDR_START: begin
          o_select_rom <= 1'b1;
          o_start_read <= 1'b1;
          ctl.addr_sel <= ADDR_HDR;
          state        <= HDR_WAIT;
        end
        HDR_WAIT: if (i_wait_done) state <= HDR_READ;
        HDR_READ: if (i_beats == 18'd5) begin
          o_stop_txn <= 1'b1;
          state      <= HDR_LATCH;
        end
        HDR_LATCH: state <= COPY_CHECK;
        // scene copy, 2 bytes per loop
        COPY_CHECK: begin
          if (ctl.copy_done) begin
            state <= LINE_WAIT_EOF;
          end else begin
            o_select_rom <= 1'b1;
            o_start_read <= 1'b1;
            ctl.addr_sel <= ADDR_COPY_RD;
            state        <= COPY_WAIT;
          end
        end
        COPY_WAIT: if (i_wait_done) state <= COPY_READ;
        COPY_READ: if (i_beats == 18'd3) begin
          o_stop_txn <= 1'b1;
          state      <= COPY_WR_START;
        end
        COPY_WR_START: begin
          o_select_rom  <= 1'b0;
          o_start_write <= 1'b1;
          ctl.addr_sel  <= ADDR_COPY_WR;
          state         <= COPY_WR;
        end
        COPY_WR: if (ctl.copy_advance) begin
          o_stop_txn <= 1'b1;
          state      <= COPY_CHECK;
        end
        // swap wins over the frame fetch
        LINE_WAIT_EOF: if (!i_do_swap && i_eof_tick) begin
          o_select_rom <= 1'b0;
          o_start_read <= 1'b1;
          ctl.addr_sel <= ADDR_FRONT_LINE;
          state        <= LINE_FILL;
        end
        LINE_FILL: if (i_wait_done) state <= LINE_READ;
        // one nibble per window pixel
        LINE_READ: if (line_last) begin
          o_stop_txn <= 1'b1;
          if (ctl.clear_pass) begin
            state <= BACK_CLR_START;
          end else if (i_y < WIN_H - 1'b1) begin
            state <= LINE_WAIT_EOL;
          end else begin
            state <= LINE_WAIT_EOF;
          end
        end
        BACK_CLR_START: begin
          o_start_write <= 1'b1;
          ctl.addr_sel  <= ADDR_BACK_LINE;
          state         <= BACK_CLR;
        end
        BACK_CLR: if (i_data_req && line_last) begin
          o_stop_txn <= 1'b1;
          // depth clear after the last window line
          state      <= (i_y == WIN_H - 1'b1) ? Z_CLR_START : LINE_WAIT_EOL;
        end
        LINE_WAIT_EOL: if (i_eol_tick) begin
          o_start_read <= 1'b1;
          ctl.addr_sel <= ADDR_FRONT_LINE;
          state        <= LINE_FILL;
        end
        Z_CLR_START: begin
          o_start_write <= 1'b1;
          ctl.addr_sel  <= ADDR_Z;
          state         <= Z_CLR;
        end
        // renderer may start once depth is far
        Z_CLR: if (i_data_req && (i_beats == Z_NIBBLES - 1'b1)) begin
          o_stop_txn     <= 1'b1;
          o_render_start <= 1'b1;
          state          <= LINE_WAIT_EOF;
        end
        default: state <= QUAD_ENTER;
      endcase
    end
  end

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(o_start_read && o_start_write));

endmodule

/* scene_loader.sv */
// scene loader datapath
// header fields, copy length and index, byte-swapped copy buffer
module scene_loader import gpu_display_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  disp_ctrl_if.dp   dp,
  input  nibble_t   i_rdata,
  input  beat_cnt_t i_beats,
  output byte_idx_t o_copy_idx,
  output nibble_t   o_wr_nibble
);

  logic [23:0] hdr;
  nibble_t     buffer [4];
  tri_count_t  tri_cnt;
  byte_idx_t   tri_wide;
  byte_idx_t   copy_len;
  logic [1:0]  wr_ptr;
  logic [1:0]  wr_sel;

  // header and copy buffer payload
  always_ff @(posedge clk) begin
    if (dp.hdr_capture) begin
      hdr[{i_beats[2:0], 2'b00} +: 4] <= i_rdata;
    end
    if (dp.buf_capture) begin
      buffer[i_beats[1:0]] <= i_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tri_cnt    <= '0;
      dp.has_tex <= 1'b0;
      o_copy_idx <= '0;
      wr_ptr     <= '0;
    end else begin
      if (dp.hdr_latch) begin
        // little endian count, high nibble first in each byte
        tri_cnt    <= {hdr[13:12], hdr[3:0], hdr[7:4]};
        dp.has_tex <= hdr[20];
        o_copy_idx <= '0;
      end else if (dp.copy_advance) begin
        o_copy_idx <= o_copy_idx + 16'd2;
      end
      if (dp.buf_capture) begin
        wr_ptr <= '0;
      end else if (dp.wr_next) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // texture block ahead of larger triangle records
  assign tri_wide     = byte_idx_t'(tri_cnt);
  assign copy_len     = dp.has_tex ? tri_wide * TRI_BYTES_TEX + TEX_BYTES
                                   : tri_wide * TRI_BYTES;
  assign dp.copy_done = (o_copy_idx == copy_len);

  // second byte goes out first
  assign wr_sel      = wr_ptr + 2'd2;
  assign o_wr_nibble = buffer[wr_sel];

endmodule

/* buf_addr_gen.sv */
// buffer address generator
// frame parity, clear pass, memory address and write data mux
module buf_addr_gen import gpu_display_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  disp_ctrl_if.dp   dp,
  input  coord_t    i_y,
  input  byte_idx_t i_copy_idx,
  input  nibble_t   i_wr_nibble,
  output mem_addr_t o_addr,
  output nibble_t   o_wdata
);

  logic      front_a;
  logic [1:0] sub_frame;
  mem_addr_t flash_ptr;
  mem_addr_t front_base;
  mem_addr_t back_base;
  coord_t    next_line;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      front_a   <= 1'b1;
      sub_frame <= '0;
      flash_ptr <= '0;
    end else begin
      if (dp.swap) begin
        front_a   <= !front_a;
        sub_frame <= '0;
      end else if (dp.frame_start && (sub_frame != 2'd2)) begin
        // saturates, only frame 1 matters
        sub_frame <= sub_frame + 1'b1;
      end
      // flash data starts after the 3 header bytes
      if (dp.hdr_latch) begin
        flash_ptr <= 24'd3;
      end else if (dp.copy_advance) begin
        flash_ptr <= mem_addr_t'(i_copy_idx) + 24'd5;
      end
    end
  end

  assign dp.clear_pass = (sub_frame == 2'd1);

  assign front_base = front_a ? FRONT_BASE_A : FRONT_BASE_B;
  assign back_base  = front_a ? FRONT_BASE_B : FRONT_BASE_A;
  // line 0 is fetched from the last raster line
  assign next_line  = (i_y == LAST_LINE) ? '0 : i_y + 1'b1;

  always_comb begin
    case (dp.addr_sel)
      ADDR_HDR:        o_addr = '0;
      ADDR_COPY_RD:    o_addr = flash_ptr;
      ADDR_COPY_WR:    o_addr = TRI_BASE + mem_addr_t'(i_copy_idx);
      ADDR_FRONT_LINE: o_addr = front_base + mem_addr_t'(next_line) * LINE_NIBBLES;
      ADDR_BACK_LINE:  o_addr = back_base + mem_addr_t'(i_y) * LINE_NIBBLES;
      ADDR_Z:          o_addr = Z_BASE;
      default:         o_addr = '0;
    endcase
  end

  always_comb begin
    case (dp.addr_sel)
      ADDR_COPY_WR: o_wdata = i_wr_nibble;
      ADDR_Z:       o_wdata = Z_FAR_NIBBLE;
      default:      o_wdata = BLACK_NIBBLE;
    endcase
  end

endmodule

/* gpu_display_top.sv */
// display and memory controller top
// vga scan, controller fsm and datapath around the memory strobe port
module gpu_display_top import gpu_display_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  output logic      o_hs,
  output logic      o_vs,
  output nibble_t   o_pixel,
  output logic      o_enter_quadmode,
  output logic      o_select_rom,
  output logic      o_start_read,
  output logic      o_start_write,
  output logic      o_stop_txn,
  output mem_addr_t o_addr,
  output nibble_t   o_wdata,
  input  logic      i_at_quadmode,
  input  nibble_t   i_rdata,
  input  logic      i_data_req,
  output logic      o_render_start,
  input  logic      i_do_swap
);

  coord_t    y;
  logic      quad_tick;
  logic      eof_tick;
  logic      eol_tick;
  beat_cnt_t beats;
  logic      wait_done;
  logic      beat_clear;
  logic      beat_step;
  logic      beat_wait;
  logic      beat_flash;
  byte_idx_t copy_idx;
  nibble_t   wr_nibble;

  disp_ctrl_if u_ctrl ();

  // read data is the front pixel stream
  vga_scan u_scan (
    .clk(clk), .rst_n(rst_n), .i_front_nibble(i_rdata),
    .o_hs(o_hs), .o_vs(o_vs), .o_pixel(o_pixel), .o_x(), .o_y(y),
    .o_quad_tick(quad_tick), .o_eof_tick(eof_tick), .o_eol_tick(eol_tick)
  );

  beat_counter u_beats (
    .clk(clk), .rst_n(rst_n), .i_clear(beat_clear), .i_step(beat_step),
    .i_wait(beat_wait), .i_flash(beat_flash), .o_beats(beats), .o_wait_done(wait_done)
  );

  display_fsm u_fsm (
    .clk(clk), .rst_n(rst_n), .ctl(u_ctrl.ctl),
    .i_at_quadmode(i_at_quadmode), .i_data_req(i_data_req), .i_do_swap(i_do_swap),
    .i_y(y), .i_quad_tick(quad_tick), .i_eof_tick(eof_tick), .i_eol_tick(eol_tick),
    .i_beats(beats), .i_wait_done(wait_done),
    .o_enter_quadmode(o_enter_quadmode), .o_select_rom(o_select_rom),
    .o_start_read(o_start_read), .o_start_write(o_start_write), .o_stop_txn(o_stop_txn),
    .o_render_start(o_render_start), .o_beat_clear(beat_clear), .o_beat_step(beat_step),
    .o_beat_wait(beat_wait), .o_beat_flash(beat_flash)
  );

  scene_loader u_loader (
    .clk(clk), .rst_n(rst_n), .dp(u_ctrl.dp), .i_rdata(i_rdata), .i_beats(beats),
    .o_copy_idx(copy_idx), .o_wr_nibble(wr_nibble)
  );

  buf_addr_gen u_addr (
    .clk(clk), .rst_n(rst_n), .dp(u_ctrl.dp), .i_y(y), .i_copy_idx(copy_idx),
    .i_wr_nibble(wr_nibble), .o_addr(o_addr), .o_wdata(o_wdata)
  );

endmodule

/* tb_clk_gen.sv */
// testbench clock and reset
// period 4, reset low for the first 3 cycles
module tb_clk_gen (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #2 o_clk = ~o_clk;
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (3) @(posedge o_clk);
    #1 o_rst_n = 1'b1;
  end

endmodule

/* tb_mem_model.sv */
// behavioral flash and RAM behind the memory strobes
// answers reads after the flash or RAM latency, requests write data every cycle
module tb_mem_model import gpu_display_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      i_enter_quadmode,
  input  logic      i_select_rom,
  input  logic      i_start_read,
  input  logic      i_start_write,
  input  logic      i_stop_txn,
  input  mem_addr_t i_addr,
  output logic      o_at_quadmode,
  output nibble_t   o_rdata,
  output logic      o_data_req,
  output logic      o_wr_fire
);

  logic [7:0]  flash_bytes [64];
  logic [31:0] seed;
  logic        s_rst_n;
  logic        s_enter;
  logic        s_rom;
  logic        s_start_rd;
  logic        s_start_wr;
  logic        s_stop;
  mem_addr_t   s_addr;
  logic        rd_rom;
  logic        rd_on;
  logic        wr_on;
  mem_addr_t   rd_base;
  int unsigned rd_idx;
  int unsigned rd_delay;
  int unsigned quad_delay;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // flash bytes high nibble first, RAM pattern folds the whole address
  function automatic nibble_t read_nibble(input logic rom, input mem_addr_t a,
                                          input int unsigned n);
    logic [7:0] b;
    mem_addr_t  ra;
    if (rom) begin
      b = flash_bytes[(a + mem_addr_t'(n >> 1)) % 64];
      return n[0] ? b[3:0] : b[7:4];
    end
    ra = a + mem_addr_t'(n);
    return ra[3:0] ^ ra[7:4] ^ ra[11:8] ^ ra[15:12] ^ ra[19:16] ^ ra[23:20];
  endfunction

  initial begin
    o_at_quadmode = 1'b0;
    o_rdata       = '0;
    o_data_req    = 1'b0;
    wr_on         = 1'b0;
    seed          = 32'h2c3c_9492;
    // one lfsr step per bit
    for (int i = 0; i < 64; i++) begin
      for (int j = 0; j < 8; j++) begin
        flash_bytes[i][j] = seed[0];
        seed = lfsr_next(seed);
      end
    end
    // header: two triangles, no texture
    flash_bytes[0] = 8'd2;
    flash_bytes[1] = 8'd0;
    flash_bytes[2] = 8'd0;
  end

  // consumed nibble, the stop cycle takes none
  assign o_wr_fire = (i_start_write || wr_on) && !i_stop_txn && o_data_req;

  always @(posedge clk) begin
    s_rst_n    = rst_n;
    s_enter    = i_enter_quadmode;
    s_rom      = i_select_rom;
    s_start_rd = i_start_read;
    s_start_wr = i_start_write;
    s_stop     = i_stop_txn;
    s_addr     = i_addr;
    #1;
    if (!s_rst_n) begin
      o_at_quadmode = 1'b0;
      o_data_req    = 1'b0;
      o_rdata       = '0;
      rd_on         = 1'b0;
      wr_on         = 1'b0;
      rd_delay      = 0;
      quad_delay    = 0;
    end else begin
      o_data_req = 1'b1;
      if (s_enter) begin
        quad_delay = 10;
      end else if (quad_delay != 0) begin
        quad_delay--;
        if (quad_delay == 0) o_at_quadmode = 1'b1;
      end
      if (s_stop) begin
        rd_on    = 1'b0;
        rd_delay = 0;
        wr_on    = 1'b0;
      end
      if (s_start_wr) wr_on = 1'b1;
      // first nibble in the cycle after the wait
      if (s_start_rd) begin
        rd_rom   = s_rom;
        rd_base  = s_addr;
        rd_idx   = 0;
        rd_delay = s_rom ? FLASH_WAIT : RAM_WAIT;
      end else if (rd_delay > 1) begin
        rd_delay--;
      end else if (rd_delay == 1) begin
        rd_delay = 0;
        rd_on    = 1'b1;
      end
      if (rd_on) begin
        o_rdata = read_nibble(rd_rom, rd_base, rd_idx);
        rd_idx++;
      end else begin
        o_rdata = '0;
      end
    end
  end

endmodule

/* tb_gpu_display.sv */
// testbench for the display and memory controller
// boot, scene copy, clear passes, line reads, blanking and buffer swap
module tb_gpu_display import gpu_display_pkg::*; ();

  localparam longint WATCHDOG_TIME = 5 * 420000 * 4;

  typedef enum logic [1:0] {WR_NONE, WR_COPY, WR_BACK, WR_Z} wr_kind_t;

  logic      clk;
  logic      rst_n;
  logic      o_hs;
  logic      o_vs;
  nibble_t   o_pixel;
  logic      o_enter_quadmode;
  logic      o_select_rom;
  logic      o_start_read;
  logic      o_start_write;
  logic      o_stop_txn;
  mem_addr_t o_addr;
  nibble_t   o_wdata;
  logic      i_at_quadmode;
  nibble_t   i_rdata;
  logic      i_data_req;
  logic      o_render_start;
  logic      i_do_swap;
  logic      wr_fire;

  int        error_count;
  int        tb_x;
  int        tb_y;
  int        quad_count;
  int        render_count;
  int        copy_steps;
  int        wr_k;
  int        line_ctr;
  int        clear_lines;
  int        z_count;
  int        reads_after_swap;
  logic      copy_phase;
  logic      front_is_a;
  logic      swapped;
  wr_kind_t  wr_kind;
  mem_addr_t front_base;
  mem_addr_t back_base;

  tb_clk_gen u_clk (.o_clk(clk), .o_rst_n(rst_n));

  tb_mem_model u_mem (
    .clk(clk), .rst_n(rst_n), .i_enter_quadmode(o_enter_quadmode),
    .i_select_rom(o_select_rom), .i_start_read(o_start_read),
    .i_start_write(o_start_write), .i_stop_txn(o_stop_txn), .i_addr(o_addr),
    .o_at_quadmode(i_at_quadmode), .o_rdata(i_rdata), .o_data_req(i_data_req),
    .o_wr_fire(wr_fire)
  );

  gpu_display_top i_dut (
    .clk(clk), .rst_n(rst_n), .o_hs(o_hs), .o_vs(o_vs), .o_pixel(o_pixel),
    .o_enter_quadmode(o_enter_quadmode), .o_select_rom(o_select_rom),
    .o_start_read(o_start_read), .o_start_write(o_start_write), .o_stop_txn(o_stop_txn),
    .o_addr(o_addr), .o_wdata(o_wdata), .i_at_quadmode(i_at_quadmode),
    .i_rdata(i_rdata), .i_data_req(i_data_req), .o_render_start(o_render_start),
    .i_do_swap(i_do_swap)
  );

  task automatic report_mismatch(input string name, input longint exp, input longint act);
    error_count++;
    $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    error_count++;
    $display("ERROR %s", msg);
    $display("** FAIL **");
    $fatal(1);
  endtask

  // two copied bytes leave second byte first, high nibble first
  function automatic nibble_t swapped_copy_nibble(input int step, input int k);
    logic [7:0] byte_a;
    logic [7:0] byte_b;
    byte_a = u_mem.flash_bytes[2 * step + 3];
    byte_b = u_mem.flash_bytes[2 * step + 4];
    case (k)
      0:       return byte_b[7:4];
      1:       return byte_b[3:0];
      2:       return byte_a[7:4];
      default: return byte_a[3:0];
    endcase
  endfunction

  assign front_base = front_is_a ? FRONT_BASE_A : FRONT_BASE_B;
  assign back_base  = front_is_a ? FRONT_BASE_B : FRONT_BASE_A;

  initial begin
    error_count = 0;
    quad_count = 0;
    render_count = 0;
    copy_steps = 0;
    wr_k = 0;
    line_ctr = 0;
    clear_lines = 0;
    z_count = 0;
    reads_after_swap = 0;
    copy_phase = 1'b1;
    front_is_a = 1'b1;
    swapped = 1'b0;
    wr_kind = WR_NONE;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      tb_x <= 0;
      tb_y <= 0;
    end else begin
      // raster position from our own counters
      assert (o_hs == !(tb_x >= 656 && tb_x < 752))
        else report_mismatch("hsync", !(tb_x >= 656 && tb_x < 752), o_hs);
      assert (o_vs == !(tb_y >= 490 && tb_y < 492))
        else report_mismatch("vsync", !(tb_y >= 490 && tb_y < 492), o_vs);
      if (!(tb_x < 320 && tb_y < 240)) begin
        assert (o_pixel == BLACK_NIBBLE) else report_mismatch("blanking", 0, o_pixel);
      end
      if (o_enter_quadmode) quad_count++;
      assert (quad_count <= 1) else report_mismatch("quad_once", 1, quad_count);
      if (!i_at_quadmode && (o_start_read || o_start_write || o_stop_txn)) begin
        report_error("memory strobe before quad mode was reached");
      end
      // line reads, front base plus line times 160
      if (o_start_read && !o_select_rom) begin
        if (copy_phase) begin
          assert (copy_steps == 22) else report_mismatch("copy_bytes", 44, copy_steps * 2);
        end
        copy_phase = 1'b0;
        if (swapped) reads_after_swap++;
        assert (o_addr == front_base + mem_addr_t'(line_ctr) * LINE_NIBBLES)
          else report_mismatch("line_addr", front_base + line_ctr * 160, o_addr);
        line_ctr = (line_ctr == 239) ? 0 : line_ctr + 1;
      end
      if (o_start_write) begin
        wr_k = 0;
        z_count = 0;
        if (copy_phase) begin
          wr_kind = WR_COPY;
          assert (o_addr == TRI_BASE + mem_addr_t'(copy_steps * 2))
            else report_mismatch("copy_addr", TRI_BASE + copy_steps * 2, o_addr);
        end else if (clear_lines < 240) begin
          wr_kind = WR_BACK;
          assert (o_addr == back_base + mem_addr_t'(clear_lines) * LINE_NIBBLES)
            else report_mismatch("back_addr", back_base + clear_lines * 160, o_addr);
          clear_lines++;
        end else begin
          wr_kind = WR_Z;
          assert (o_addr == Z_BASE) else report_mismatch("z_addr", Z_BASE, o_addr);
        end
      end
      if (wr_fire) begin
        case (wr_kind)
          WR_COPY: begin
            assert (o_wdata == swapped_copy_nibble(copy_steps, wr_k))
              else report_mismatch("copy_data", swapped_copy_nibble(copy_steps, wr_k),
                                   o_wdata);
            wr_k++;
            if (wr_k == 4) copy_steps++;
          end
          WR_BACK: assert (o_wdata == BLACK_NIBBLE)
            else report_mismatch("back_data", BLACK_NIBBLE, o_wdata);
          WR_Z: begin
            assert (o_wdata == Z_FAR_NIBBLE)
              else report_mismatch("z_data", Z_FAR_NIBBLE, o_wdata);
            z_count++;
          end
          default: report_error("write data requested outside a write");
        endcase
      end
      // render start only right after a full depth clear
      if (o_render_start) begin
        assert (wr_kind == WR_Z) else report_error("render start without a depth clear");
        assert (z_count == Z_NIBBLES) else report_mismatch("z_count", Z_NIBBLES, z_count);
        render_count++;
        clear_lines = 0;
        wr_kind = WR_NONE;
      end
      tb_x <= (tb_x == 799) ? 0 : tb_x + 1;
      if (tb_x == 799) tb_y <= (tb_y == 524) ? 0 : tb_y + 1;
    end
  end

  initial begin
    i_do_swap = 1'b0;
    wait (rst_n);
    wait (render_count == 1);
    repeat (100) @(posedge clk);
    #1;
    i_do_swap = 1'b1;
    front_is_a = !front_is_a;
    swapped = 1'b1;
    @(posedge clk);
    #1;
    i_do_swap = 1'b0;
    wait (render_count == 2);
    repeat (10) @(posedge clk);
    if (quad_count != 1) report_mismatch("quad_once", 1, quad_count);
    if (reads_after_swap < 240) report_mismatch("reads_after_swap", 240, reads_after_swap);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("ERROR run did not finish in time");
    $display("** FAIL **");
    $fatal(1);
  end

endmodule

/* gpu_display.f */
gpu_display_pkg.sv
disp_ctrl_if.sv
vga_scan.sv
beat_counter.sv
display_fsm.sv
scene_loader.sv
buf_addr_gen.sv
gpu_display_top.sv
tb_clk_gen.sv
tb_mem_model.sv
tb_gpu_display.sv

/* Bender.yml */
package:
  name: gpu_display

sources:
  - gpu_display_pkg.sv
  - disp_ctrl_if.sv
  - vga_scan.sv
  - beat_counter.sv
  - display_fsm.sv
  - scene_loader.sv
  - buf_addr_gen.sv
  - gpu_display_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_mem_model.sv
      - tb_gpu_display.sv
